// File: common/table_pkg.sv
package table_pkg;

    typedef logic [10:0] coord_t;
    typedef logic [11:0] rgb_t;
    typedef logic [3:0]  rank_t;
    typedef logic [1:0]  suit_t;
    typedef logic [2:0]  slot_t;

    // Packed as {valid, suit, rank}.
    typedef logic [6:0]  card_t;

    // 800x600@60, positive syncs.
    localparam coord_t H_ACTIVE = 11'd800;
    localparam coord_t H_FP     = 11'd40;
    localparam coord_t H_SYNC   = 11'd128;
    localparam coord_t H_TOTAL  = 11'd1056;

    localparam coord_t V_ACTIVE = 11'd600;
    localparam coord_t V_FP     = 11'd1;
    localparam coord_t V_SYNC   = 11'd4;
    localparam coord_t V_TOTAL  = 11'd628;

    localparam rgb_t COLOR_FELT   = 12'h074;
    localparam rgb_t COLOR_WHITE  = 12'hfff;
    localparam rgb_t COLOR_BLACK  = 12'h000;
    localparam rgb_t COLOR_RED    = 12'he00;
    localparam rgb_t COLOR_CURSOR = 12'hff0;

    // Legal ranks are 1 to RANK_MAX.
    localparam rank_t RANK_MAX = 4'd13;

    localparam int N_SLOTS = 6;

    // Card placement, slot k starts at CARD_X0 + k * CARD_PITCH.
    localparam coord_t CARD_X0    = 11'd100;
    localparam coord_t CARD_Y0    = 11'd400;
    localparam coord_t CARD_PITCH = 11'd100;
    localparam coord_t CARD_W     = 11'd40;
    localparam coord_t CARD_H     = 11'd60;

    // Rank bar, measured inside the card.
    localparam coord_t BAR_X    = 11'd4;
    localparam coord_t BAR_W    = 11'd8;
    localparam coord_t BAR_STEP = 11'd4;

    localparam coord_t CURSOR_SIZE = 11'd8;

endpackage

// File: common/vga_if.sv
interface vga_if;
    import table_pkg::*;

    coord_t hcount;
    coord_t vcount;
    logic   hsync;
    logic   vsync;
    logic   hblnk;
    logic   vblnk;
    rgb_t   rgb;

    modport src (
        output hcount,
        output vcount,
        output hsync,
        output vsync,
        output hblnk,
        output vblnk,
        output rgb
    );

    modport snk (
        input hcount,
        input vcount,
        input hsync,
        input vsync,
        input hblnk,
        input vblnk,
        input rgb
    );

endinterface

// File: rtl/table_raster.sv
module table_raster (
    input  logic clk,
    input  logic arst_n,
    vga_if.src   vga,
    output logic frame_start
);
    import table_pkg::*;

    coord_t h_cnt;
    coord_t v_cnt;
    logic   h_active;
    logic   v_active;
    logic   h_sync_on;
    logic   v_sync_on;

    // Free-running position counters.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            h_cnt <= '0;
            v_cnt <= '0;
        end else if (h_cnt == H_TOTAL - 11'd1) begin
            h_cnt <= '0;
            if (v_cnt == V_TOTAL - 11'd1) begin
                v_cnt <= '0;
            end else begin
                v_cnt <= v_cnt + 11'd1;
            end
        end else begin
            h_cnt <= h_cnt + 11'd1;
        end
    end

    assign h_active  = (h_cnt < H_ACTIVE);
    assign v_active  = (v_cnt < V_ACTIVE);
    assign h_sync_on = (h_cnt >= H_ACTIVE + H_FP) && (h_cnt < H_ACTIVE + H_FP + H_SYNC);
    assign v_sync_on = (v_cnt >= V_ACTIVE + V_FP) && (v_cnt < V_ACTIVE + V_FP + V_SYNC);

    // Registered stream, all fields aligned to the same pixel.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            vga.hcount  <= '0;
            vga.vcount  <= '0;
            vga.hsync   <= 1'b0;
            vga.vsync   <= 1'b0;
            vga.hblnk   <= 1'b1;
            vga.vblnk   <= 1'b1;
            vga.rgb     <= COLOR_BLACK;
            frame_start <= 1'b0;
        end else begin
            vga.hcount  <= h_cnt;
            vga.vcount  <= v_cnt;
            vga.hsync   <= h_sync_on;
            vga.vsync   <= v_sync_on;
            vga.hblnk   <= !h_active;
            vga.vblnk   <= !v_active;
            vga.rgb     <= (h_active && v_active) ? COLOR_FELT : COLOR_BLACK;
            // High while pixel 0,0 leaves the raster.
            frame_start <= (h_cnt == '0) && (v_cnt == '0);
        end
    end

endmodule

// File: card/card_deal.sv
module card_deal (
    input  logic             clk,
    input  logic             arst_n,
    input  logic             frame_start,
    input  logic             deal,
    input  logic             clear,
    input  table_pkg::slot_t deal_slot,
    input  table_pkg::rank_t deal_rank,
    input  table_pkg::suit_t deal_suit,
    output table_pkg::card_t cards [table_pkg::N_SLOTS]
);
    import table_pkg::*;

    card_t pending [N_SLOTS];
    logic  rank_ok;
    logic  slot_ok;
    logic  deal_ok;

    assign rank_ok = (deal_rank != '0) && (deal_rank <= RANK_MAX);
    assign slot_ok = (deal_slot < N_SLOTS);
    assign deal_ok = deal && rank_ok && slot_ok;

    // Strobes land in the pending copy, clear has priority.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < N_SLOTS; i++) begin
                pending[i] <= '0;
            end
        end else if (clear) begin
            for (int i = 0; i < N_SLOTS; i++) begin
                pending[i] <= '0;
            end
        end else if (deal_ok) begin
            pending[deal_slot] <= {1'b1, deal_suit, deal_rank};
        end
    end

    // Visible copy only changes between frames.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < N_SLOTS; i++) begin
                cards[i] <= '0;
            end
        end else if (frame_start) begin
            cards <= pending;
        end
    end

endmodule

// File: card/card_layer.sv
module card_layer #(
    parameter table_pkg::slot_t SLOT = '0
) (
    input  logic             clk,
    input  logic             arst_n,
    input  table_pkg::card_t card,
    vga_if.snk               upstream,
    vga_if.src               downstream
);
    import table_pkg::*;

    localparam coord_t X0 = CARD_X0 + coord_t'(SLOT) * CARD_PITCH;

    logic   valid;
    suit_t  suit;
    rank_t  rank;
    coord_t lx;
    coord_t ly;
    coord_t bar_h;
    logic   in_card;
    logic   on_border;
    logic   on_bar;
    rgb_t   rgb_nxt;

    assign {valid, suit, rank} = card;

    // Position relative to the card's top-left corner.
    assign lx    = upstream.hcount - X0;
    assign ly    = upstream.vcount - CARD_Y0;
    assign bar_h = coord_t'(rank) * BAR_STEP;

    assign in_card = valid
                  && (upstream.hcount >= X0) && (upstream.hcount < X0 + CARD_W)
                  && (upstream.vcount >= CARD_Y0) && (upstream.vcount < CARD_Y0 + CARD_H);

    assign on_border = (lx == '0) || (lx == CARD_W - 11'd1)
                    || (ly == '0) || (ly == CARD_H - 11'd1);

    // Bar grows upward from the bottom inner row.
    assign on_bar = (lx >= BAR_X) && (lx < BAR_X + BAR_W)
                 && (ly + bar_h >= CARD_H - 11'd1);

    always_comb begin
        if (!in_card) begin
            rgb_nxt = upstream.rgb;
        end else if (on_border) begin
            rgb_nxt = COLOR_BLACK;
        end else if (on_bar) begin
            // Suits 0 and 1 are red.
            rgb_nxt = suit[1] ? COLOR_BLACK : COLOR_RED;
        end else begin
            rgb_nxt = COLOR_WHITE;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            downstream.hcount <= '0;
            downstream.vcount <= '0;
            downstream.hsync  <= 1'b0;
            downstream.vsync  <= 1'b0;
            downstream.hblnk  <= 1'b1;
            downstream.vblnk  <= 1'b1;
            downstream.rgb    <= COLOR_BLACK;
        end else begin
            downstream.hcount <= upstream.hcount;
            downstream.vcount <= upstream.vcount;
            downstream.hsync  <= upstream.hsync;
            downstream.vsync  <= upstream.vsync;
            downstream.hblnk  <= upstream.hblnk;
            downstream.vblnk  <= upstream.vblnk;
            downstream.rgb    <= rgb_nxt;
        end
    end

endmodule

// File: rtl/draw_cursor.sv
module draw_cursor (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              frame_start,
    input  table_pkg::coord_t cursor_x,
    input  table_pkg::coord_t cursor_y,
    vga_if.snk                upstream,
    output logic              hs,
    output logic              vs,
    output logic [3:0]        r,
    output logic [3:0]        g,
    output logic [3:0]        b
);
    import table_pkg::*;

    coord_t cur_x;
    coord_t cur_y;
    coord_t dx;
    coord_t dy;
    logic   in_cursor;
    rgb_t   rgb_nxt;

    // Position is held for a whole frame.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cur_x <= '0;
            cur_y <= '0;
        end else if (frame_start) begin
            cur_x <= cursor_x;
            cur_y <= cursor_y;
        end
    end

    assign dx = upstream.hcount - cur_x;
    assign dy = upstream.vcount - cur_y;

    assign in_cursor = !upstream.hblnk && !upstream.vblnk
                    && (upstream.hcount >= cur_x) && (dx < CURSOR_SIZE)
                    && (upstream.vcount >= cur_y) && (dy < CURSOR_SIZE);

    assign rgb_nxt = in_cursor ? COLOR_CURSOR : upstream.rgb;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            hs        <= 1'b0;
            vs        <= 1'b0;
            {r, g, b} <= COLOR_BLACK;
        end else begin
            hs        <= upstream.hsync;
            vs        <= upstream.vsync;
            {r, g, b} <= rgb_nxt;
        end
    end

endmodule

// File: rtl/table_top.sv
module table_top (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              deal,
    input  logic              clear,
    input  table_pkg::slot_t  deal_slot,
    input  table_pkg::rank_t  deal_rank,
    input  table_pkg::suit_t  deal_suit,
    input  table_pkg::coord_t cursor_x,
    input  table_pkg::coord_t cursor_y,
    output logic              hs,
    output logic              vs,
    output logic [3:0]        r,
    output logic [3:0]        g,
    output logic [3:0]        b
);
    import table_pkg::*;

    // link[0] is the bare raster, link[N_SLOTS] has every card drawn.
    vga_if link [N_SLOTS + 1] ();

    card_t cards [N_SLOTS];
    logic  frame_start;

    table_raster u_table_raster (
        .clk,
        .arst_n,
        .vga(link[0]),
        .frame_start
    );

    card_deal u_card_deal (
        .clk,
        .arst_n,
        .frame_start,
        .deal,
        .clear,
        .deal_slot,
        .deal_rank,
        .deal_suit,
        .cards
    );

    for (genvar k = 0; k < N_SLOTS; k++) begin : g_layer
        card_layer #(
            .SLOT(slot_t'(k))
        ) u_card_layer (
            .clk,
            .arst_n,
            .card(cards[k]),
            .upstream(link[k]),
            .downstream(link[k + 1])
        );
    end

    draw_cursor u_draw_cursor (
        .clk,
        .arst_n,
        .frame_start,
        .cursor_x,
        .cursor_y,
        .upstream(link[N_SLOTS]),
        .hs,
        .vs,
        .r,
        .g,
        .b
    );

endmodule

// File: sim/table_checker.sv
module table_checker (
    input logic              clk,
    input logic              arst_n,
    input logic              hs,
    input logic              vs,
    input logic              frame_start,
    input logic              blank,
    input table_pkg::rgb_t   rgb,
    input table_pkg::card_t  cards [table_pkg::N_SLOTS]
);
    import table_pkg::*;

    int fail_count = 0;

    reset_quiet: assert property (@(posedge clk) !arst_n |-> !hs && !vs)
        else begin
            $error("hs or vs active during reset");
            fail_count++;
        end

    // Last link before the cursor stage.
    blank_black: assert property (@(posedge clk) disable iff (!arst_n)
            blank |-> rgb == COLOR_BLACK)
        else begin
            $error("colour not black during blanking");
            fail_count++;
        end

    frame_pulse: assert property (@(posedge clk) disable iff (!arst_n)
            frame_start |=> !frame_start)
        else begin
            $error("frame_start longer than one cycle");
            fail_count++;
        end

    for (genvar k = 0; k < N_SLOTS; k++) begin : g_rank
        rank_legal: assert property (@(posedge clk) disable iff (!arst_n)
                cards[k][6] |-> (cards[k][3:0] != '0) && (cards[k][3:0] <= RANK_MAX))
            else begin
                $error("visible slot %0d holds an illegal rank", k);
                fail_count++;
            end
    end

endmodule

bind table_top table_checker u_table_checker (
    .clk,
    .arst_n,
    .hs,
    .vs,
    .frame_start,
    .blank(link[table_pkg::N_SLOTS].hblnk || link[table_pkg::N_SLOTS].vblnk),
    .rgb(link[table_pkg::N_SLOTS].rgb),
    .cards
);

// File: sim/table_tb.sv
module table_tb;
    import table_pkg::*;

    localparam int     CLK_PERIOD      = 20;
    localparam int     MID_LINE        = 300;
    localparam int     WATCHDOG_CYCLES = 8 * int'(H_TOTAL) * int'(V_TOTAL);
    localparam coord_t HS_START        = H_ACTIVE + H_FP;
    localparam coord_t VS_START        = V_ACTIVE + V_FP;

    logic       clk = 1'b0;
    logic       arst_n;
    logic       deal;
    logic       clear;
    slot_t      deal_slot;
    rank_t      deal_rank;
    suit_t      deal_suit;
    coord_t     cursor_x;
    coord_t     cursor_y;
    logic       hs;
    logic       vs;
    logic [3:0] r;
    logic [3:0] g;
    logic [3:0] b;

    // Slot model for the pending copy and the copy on screen.
    logic   pend_valid [N_SLOTS];
    suit_t  pend_suit  [N_SLOTS];
    rank_t  pend_rank  [N_SLOTS];
    logic   vis_valid  [N_SLOTS];
    suit_t  vis_suit   [N_SLOTS];
    rank_t  vis_rank   [N_SLOTS];
    coord_t vis_cur_x = '0;
    coord_t vis_cur_y = '0;

    // Raster position recovered from the sync edges at the pins.
    coord_t mon_x     = '0;
    coord_t mon_y     = '0;
    logic   h_lock    = 1'b0;
    logic   v_lock    = 1'b0;
    logic   pix_hs    = 1'b0;
    logic   pix_vs    = 1'b0;
    rgb_t   pix_rgb   = '0;
    int     frame_cnt = 0;

    table_top UUT (
        .clk,
        .arst_n,
        .deal,
        .clear,
        .deal_slot,
        .deal_rank,
        .deal_suit,
        .cursor_x,
        .cursor_y,
        .hs,
        .vs,
        .r,
        .g,
        .b
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic fail_run(string what);
        $display("Error at time %0t: %s", $time, what);
        $display("Result: FAILED");
        $fatal(1, "Simulation stopped on the first mismatch.");
    endtask

    task automatic check_rgb(rgb_t got, rgb_t exp, coord_t x, coord_t y);
        if (got !== exp) begin
            fail_run($sformatf("pixel (%0d,%0d) is %h, expected %h", x, y, got, exp));
        end
    endtask

    task automatic check_blank(rgb_t got, coord_t x, coord_t y);
        if (got !== COLOR_BLACK) begin
            fail_run($sformatf("blank pixel (%0d,%0d) is %h, expected black", x, y, got));
        end
    endtask

    task automatic check_sync(logic got, logic exp, string name, coord_t x, coord_t y);
        if (got !== exp) begin
            fail_run($sformatf("%s at (%0d,%0d) is %b, expected %b", name, x, y, got, exp));
        end
    endtask

    // Colour of an active pixel as the table rules describe it.
    function automatic rgb_t expected_pixel(coord_t x, coord_t y);
        rgb_t colour;
        int   lx;
        int   ly;
        int   bar_top;
        colour = COLOR_FELT;
        for (int k = 0; k < N_SLOTS; k++) begin
            lx      = int'(x) - (int'(CARD_X0) + k * int'(CARD_PITCH));
            ly      = int'(y) - int'(CARD_Y0);
            bar_top = int'(CARD_H) - 1 - int'(vis_rank[k]) * int'(BAR_STEP);
            if (vis_valid[k] && lx >= 0 && lx < int'(CARD_W) && ly >= 0 && ly < int'(CARD_H)) begin
                if (lx == 0 || lx == int'(CARD_W) - 1 || ly == 0 || ly == int'(CARD_H) - 1) begin
                    colour = COLOR_BLACK;
                end else if (lx >= int'(BAR_X) && lx < int'(BAR_X + BAR_W) && ly >= bar_top) begin
                    colour = (vis_suit[k] < 2) ? COLOR_RED : COLOR_BLACK;
                end else begin
                    colour = COLOR_WHITE;
                end
            end
        end
        if (int'(x) >= int'(vis_cur_x) && int'(x) < int'(vis_cur_x) + int'(CURSOR_SIZE)
                && int'(y) >= int'(vis_cur_y) && int'(y) < int'(vis_cur_y) + int'(CURSOR_SIZE)) begin
            colour = COLOR_CURSOR;
        end
        return colour;
    endfunction

    task automatic apply_strobe_model(logic do_clear, logic do_deal, slot_t s, rank_t rk,
                                      suit_t su);
        if (do_clear) begin
            for (int k = 0; k < N_SLOTS; k++) begin
                pend_valid[k] = 1'b0;
            end
        end else if (do_deal && rk >= 1 && rk <= RANK_MAX && s < N_SLOTS) begin
            pend_valid[s] = 1'b1;
            pend_suit[s]  = su;
            pend_rank[s]  = rk;
        end
    endtask

    task automatic start_frame_model();
        for (int k = 0; k < N_SLOTS; k++) begin
            vis_valid[k] = pend_valid[k];
            vis_suit[k]  = pend_suit[k];
            vis_rank[k]  = pend_rank[k];
        end
        vis_cur_x = cursor_x;
        vis_cur_y = cursor_y;
    endtask

    task automatic issue_strobe(logic do_clear, logic do_deal, slot_t s, rank_t rk, suit_t su);
        clear     = do_clear;
        deal      = do_deal;
        deal_slot = s;
        deal_rank = rk;
        deal_suit = su;
        apply_strobe_model(do_clear, do_deal, s, rk, su);
        @(negedge clk);
        clear = 1'b0;
        deal  = 1'b0;
    endtask

    task automatic wait_mid_frame(int frame);
        do begin
            @(negedge clk);
        end while (!(frame_cnt == frame && mon_y == coord_t'(MID_LINE)));
    endtask

    task automatic wait_frame(int frame);
        do begin
            @(negedge clk);
        end while (frame_cnt < frame);
    endtask

    // Pins are sampled mid-cycle. hs rises on pixel HS_START and vs on line VS_START.
    always @(negedge clk) begin
        pix_rgb <= {r, g, b};
        pix_hs  <= hs;
        pix_vs  <= vs;
        if (hs && !pix_hs) begin
            mon_x  <= HS_START;
            h_lock <= 1'b1;
        end else if (mon_x == H_TOTAL - 11'd1) begin
            mon_x <= '0;
        end else begin
            mon_x <= mon_x + 11'd1;
        end
        if (vs && !pix_vs) begin
            mon_y  <= VS_START;
            v_lock <= 1'b1;
        end else if (mon_x == H_TOTAL - 11'd1) begin
            mon_y <= (mon_y == V_TOTAL - 11'd1) ? '0 : mon_y + 11'd1;
        end
    end

    always @(posedge clk) begin
        if (h_lock && v_lock) begin
            if (mon_x == '0 && mon_y == '0) begin
                start_frame_model();
                frame_cnt++;
            end
            check_sync(pix_hs, mon_x >= HS_START && mon_x < HS_START + H_SYNC, "hs", mon_x, mon_y);
            check_sync(pix_vs, mon_y >= VS_START && mon_y < VS_START + V_SYNC, "vs", mon_x, mon_y);
            if (mon_x < H_ACTIVE && mon_y < V_ACTIVE) begin
                check_rgb(pix_rgb, expected_pixel(mon_x, mon_y), mon_x, mon_y);
            end else begin
                check_blank(pix_rgb, mon_x, mon_y);
            end
        end
    end

    always @(posedge clk) begin
        if (UUT.u_table_checker.fail_count != 0) begin
            fail_run($sformatf("%0d assertion failures in the checker",
                               UUT.u_table_checker.fail_count));
        end
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Timeout: the run did not finish within %0d clock cycles.", WATCHDOG_CYCLES);
        $display("Result: FAILED");
        $fatal(1, "Watchdog expired.");
    end

    initial begin
        int k;
        int x0;
        void'($urandom(32'hf0c4_07a9));
        arst_n    = 1'b0;
        deal      = 1'b0;
        clear     = 1'b0;
        deal_slot = '0;
        deal_rank = '0;
        deal_suit = '0;
        cursor_x  = '0;
        cursor_y  = '0;
        for (int i = 0; i < N_SLOTS; i++) begin
            pend_valid[i] = 1'b0;
            pend_suit[i]  = '0;
            pend_rank[i]  = '0;
            vis_valid[i]  = 1'b0;
            vis_suit[i]   = '0;
            vis_rank[i]   = '0;
        end
        repeat (5) @(negedge clk);
        arst_n = 1'b1;

        // Frame 1 shows the bare table with the cursor at 0,0.
        wait_mid_frame(1);

        // Legal deals in the middle of frame 1.
        for (int i = 0; i < N_SLOTS; i++) begin
            issue_strobe(1'b0, 1'b1, slot_t'(i), rank_t'($urandom_range(1, 13)),
                         suit_t'($urandom_range(0, 3)));
        end
        repeat (3) begin
            issue_strobe(1'b0, 1'b1, slot_t'($urandom_range(0, N_SLOTS - 1)),
                         rank_t'($urandom_range(1, 13)), suit_t'($urandom_range(0, 3)));
        end
        wait_mid_frame(2);

        // Bad ranks and bad slots.
        issue_strobe(1'b0, 1'b1, slot_t'($urandom_range(0, N_SLOTS - 1)), 4'd0,
                     suit_t'($urandom_range(0, 3)));
        issue_strobe(1'b0, 1'b1, slot_t'($urandom_range(0, N_SLOTS - 1)), 4'd14,
                     suit_t'($urandom_range(0, 3)));
        issue_strobe(1'b0, 1'b1, slot_t'($urandom_range(0, N_SLOTS - 1)), 4'd15,
                     suit_t'($urandom_range(0, 3)));
        issue_strobe(1'b0, 1'b1, 3'd6, rank_t'($urandom_range(1, 13)),
                     suit_t'($urandom_range(0, 3)));
        issue_strobe(1'b0, 1'b1, 3'd7, rank_t'($urandom_range(1, 13)),
                     suit_t'($urandom_range(0, 3)));

        // Cursor moves onto a card.
        k        = $urandom_range(0, N_SLOTS - 1);
        x0       = int'(CARD_X0) + k * int'(CARD_PITCH);
        cursor_x = coord_t'(x0 - 4 + int'($urandom_range(0, int'(CARD_W) - 1)));
        cursor_y = coord_t'(int'(CARD_Y0) - 4 + int'($urandom_range(0, int'(CARD_H) - 1)));
        wait_mid_frame(3);

        // Clear and deal together while the cursor hangs off the active area.
        cursor_x = H_ACTIVE - coord_t'($urandom_range(1, int'(CURSOR_SIZE) - 1));
        cursor_y = V_ACTIVE - coord_t'($urandom_range(1, int'(CURSOR_SIZE) - 1));
        issue_strobe(1'b1, 1'b1, slot_t'($urandom_range(0, N_SLOTS - 1)),
                     rank_t'($urandom_range(1, 13)), suit_t'($urandom_range(0, 3)));
        wait_frame(5);

        if (UUT.u_table_checker.fail_count == 0) begin
            $display("Result: PASSED");
            $finish;
        end else begin
            $display("Error at time %0t: %0d assertion failures in the checker", $time,
                     UUT.u_table_checker.fail_count);
            $display("Result: FAILED");
            $fatal(1, "Assertion failures were reported.");
        end
    end

endmodule

// File: verilog.f
common/table_pkg.sv
common/vga_if.sv
rtl/table_raster.sv
card/card_deal.sv
card/card_layer.sv
rtl/draw_cursor.sv
rtl/table_top.sv
sim/table_checker.sv
sim/table_tb.sv

// File: Bender.yml
package:
  name: card_table

sources:
  - common/table_pkg.sv
  - common/vga_if.sv
  - rtl/table_raster.sv
  - card/card_deal.sv
  - card/card_layer.sv
  - rtl/draw_cursor.sv
  - rtl/table_top.sv
  - target: simulation
    files:
      - sim/table_checker.sv
      - sim/table_tb.sv
